// ==== sim.f ====
+incdir+source
source/tscPkg.sv
source/wordMemory.sv
source/regFile.sv
source/alu.sv
source/controlUnit.sv
source/cpuSequencer.sv
source/instCounter.sv
source/execDatapath.sv
source/tscCore.sv
verification/clockGen.sv
verification/tscCore_assert.sv
verification/tscTb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ps
`include "tsc_consts.svh"

module alu import tscPkg::*; (
	input aluOp_t op,
	input word_t a,
	input word_t b,
	input logic [3:0] opcode,
	output word_t result,
	output logic branchTaken
);

	always_comb begin
		case (op)
			ADD: result = a + b;
			SUB: result = a - b;
			AND: result = a & b;
			ORR: result = a | b;
			NOT: result = ~a;
			TCP: result = ~a + 1'b1;
			SHL: result = {a[`WORD_SIZE-2:0], 1'b0};
			SHR: result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]}; // keeps sign.
			default: result = '0;
		endcase
	end

	always_comb begin
		case (opcode)
			`BNE_OP: branchTaken = (a != b);
			`BEQ_OP: branchTaken = (a == b);
			`BGZ_OP: branchTaken = ($signed(a) > 0);
			`BLZ_OP: branchTaken = a[`WORD_SIZE-1];
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps
`include "tsc_consts.svh"

module controlUnit import tscPkg::*; (
	input instrWord_t instr,
	input logic decodeValid,
	output ctrlSigs_t ctrl
);

	always_comb begin
		ctrl = '0; // flushed or unknown opcode.
		if (decodeValid) begin
			case (instr.opcode)
				`ALU_OP: begin
					case (instr.func)
						`FUNC_ADD, `FUNC_SUB, `FUNC_AND, `FUNC_ORR,
						`FUNC_NOT, `FUNC_TCP, `FUNC_SHL, `FUNC_SHR: begin
							ctrl.regWrite = 1'b1;
							ctrl.aluOp = aluOp_t'(instr.func[2:0]);
							ctrl.destSel = DEST_RD;
							ctrl.wbSel = WB_ALU;
						end
						`FUNC_WWD: ctrl.isWwd = 1'b1;
						`FUNC_HLT: ctrl.isHalt = 1'b1;
						`FUNC_JPR: ctrl.pcSrc = PC_REG;
						`FUNC_JRL: begin
							ctrl.pcSrc = PC_REG;
							ctrl.regWrite = 1'b1;
							ctrl.destSel = DEST_R2;
							ctrl.wbSel = WB_LINK;
						end
						default: ctrl = '0;
					endcase
				end
				`ADI_OP, `ORI_OP: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrcB = 1'b1;
					ctrl.destSel = DEST_RT;
					ctrl.wbSel = WB_ALU;
					ctrl.aluOp = (instr.opcode == `ADI_OP) ? ADD : ORR;
					ctrl.immSel = (instr.opcode == `ADI_OP) ? IMM_SIGN : IMM_ZERO;
				end
				`LHI_OP: begin
					ctrl.regWrite = 1'b1;
					ctrl.destSel = DEST_RT;
					ctrl.wbSel = WB_IMM;
					ctrl.immSel = IMM_HIGH;
				end
				`LWD_OP: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrcB = 1'b1; // address is rs + imm.
					ctrl.memRead = 1'b1;
					ctrl.destSel = DEST_RT;
					ctrl.wbSel = WB_MEM;
				end
				`SWD_OP: begin
					ctrl.aluSrcB = 1'b1;
					ctrl.memWrite = 1'b1;
				end
				`BNE_OP, `BEQ_OP, `BGZ_OP, `BLZ_OP: begin
					ctrl.branch = 1'b1; // compares rs with rt.
				end
				`JMP_OP: ctrl.pcSrc = PC_TARGET;
				`JAL_OP: begin
					ctrl.pcSrc = PC_TARGET;
					ctrl.regWrite = 1'b1;
					ctrl.destSel = DEST_R2;
					ctrl.wbSel = WB_LINK;
				end
				default: ctrl = '0;
			endcase
		end
	end

endmodule

// ==== source/cpuSequencer.sv ====
`timescale 1ns/1ps

module cpuSequencer import tscPkg::*; (
	input logic clk,
	input logic rstN,
	input logic start,
	input ctrlSigs_t ctrl,
	output stageStrobes_t strobes,
	output logic decodeValid,
	output logic halted
);

	typedef enum logic [2:0] {
		IDLE, FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALTED
	} state_t;

	state_t state;
	state_t nextState;

	always_ff @(posedge clk) begin
		if (!rstN)
			state <= IDLE;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: if (start) nextState = FETCH;
			FETCH: nextState = DECODE;
			DECODE: nextState = EXECUTE;
			EXECUTE: begin
				if (ctrl.memRead || ctrl.memWrite)
					nextState = MEMORY;
				else
					nextState = WRITEBACK;
			end
			MEMORY: nextState = WRITEBACK;
			WRITEBACK: nextState = ctrl.isHalt ? HALTED : FETCH;
			HALTED: nextState = HALTED; // left only by reset.
			default: nextState = IDLE;
		endcase
	end

	always_comb begin
		strobes.irLoad = (state == FETCH);
		strobes.opLatch = (state == DECODE);
		strobes.exLatch = (state == EXECUTE);
		strobes.memAccess = (state == MEMORY);
		strobes.commit = (state == WRITEBACK);
	end

	assign decodeValid = (state == DECODE) || (state == EXECUTE) ||
		(state == MEMORY) || (state == WRITEBACK);
	assign halted = (state == HALTED);

endmodule

// ==== source/execDatapath.sv ====
`timescale 1ns/1ps
`include "tsc_consts.svh"

module execDatapath import tscPkg::*; (
	input logic clk,
	input logic rstN,
	input stageStrobes_t strobes,
	input ctrlSigs_t ctrl,
	input instrWord_t instrIn,
	output instrWord_t instr,
	output word_t pc,
	output word_t memAddr,
	output word_t memWrData,
	input word_t memRdData,
	output logic memWrEn,
	output word_t outputPort,
	output logic wwdStrobe
);

	word_t rdA, rdB;
	word_t opA, opB;
	word_t aluB, aluRes, resultReg, mdr;
	word_t immSign, immExt, pcPlus1, jumpTarget, wbData, outReg;
	logic aluTaken, takenReg;
	logic [1:0] wrAddr;

	assign immSign = {{(`WORD_SIZE-8){instr[7]}}, instr[7:0]};
	assign pcPlus1 = pc + 1'b1;
	assign jumpTarget = {pc[`WORD_SIZE-1:12], instr[11:0]};

	always_comb begin
		case (ctrl.immSel)
			IMM_ZERO: immExt = {{(`WORD_SIZE-8){1'b0}}, instr[7:0]};
			IMM_HIGH: immExt = {instr[7:0], 8'h00};
			default: immExt = immSign;
		endcase
	end

	regFile regFile_i (
		.clk(clk),
		.wrEn(strobes.commit && ctrl.regWrite),
		.rdAddrA(instr.rs),
		.rdAddrB(instr.rt),
		.wrAddr(wrAddr),
		.wrData(wbData),
		.rdDataA(rdA),
		.rdDataB(rdB)
	);

	assign aluB = ctrl.aluSrcB ? immExt : opB;

	alu alu_i (
		.op(ctrl.aluOp),
		.a(opA),
		.b(aluB),
		.opcode(instr.opcode),
		.result(aluRes),
		.branchTaken(aluTaken)
	);

	always_ff @(posedge clk) begin
		if (strobes.irLoad)
			instr <= instrIn;
		if (strobes.opLatch) begin
			opA <= rdA;
			opB <= rdB;
		end
		if (strobes.exLatch) begin
			resultReg <= aluRes;
			takenReg <= aluTaken && ctrl.branch;
		end
		if (strobes.memAccess && ctrl.memRead)
			mdr <= memRdData;
	end

	always_comb begin
		case (ctrl.destSel)
			DEST_RT: wrAddr = instr.rt;
			DEST_R2: wrAddr = `LINK_REG;
			default: wrAddr = instr.rd;
		endcase
		case (ctrl.wbSel)
			WB_MEM: wbData = mdr;
			WB_LINK: wbData = pcPlus1;
			WB_IMM: wbData = immExt;
			default: wbData = resultReg;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			outReg <= '0;
		end else if (strobes.commit) begin
			case (ctrl.pcSrc)
				PC_TARGET: pc <= jumpTarget;
				PC_REG: pc <= opA;
				default: pc <= takenReg ? pcPlus1 + immSign : pcPlus1;
			endcase
			if (ctrl.isWwd)
				outReg <= opA;
		end
	end

	assign memAddr = resultReg;
	assign memWrData = opB; // rt holds the store data.
	assign memWrEn = strobes.memAccess && ctrl.memWrite;

	// value is visible during the strobe itself.
	assign wwdStrobe = strobes.commit && ctrl.isWwd;
	assign outputPort = wwdStrobe ? opA : outReg;

endmodule

// ==== source/instCounter.sv ====
`timescale 1ns/1ps

module instCounter import tscPkg::*; (
	input logic clk,
	input logic rstN,
	input logic retire,
	output word_t numInst
);

	always_ff @(posedge clk) begin
		if (!rstN)
			numInst <= '0;
		else if (retire)
			numInst <= numInst + 1'b1; // wraps.
	end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile import tscPkg::*; (
	input logic clk,
	input logic wrEn,
	input logic [1:0] rdAddrA,
	input logic [1:0] rdAddrB,
	input logic [1:0] wrAddr,
	input word_t wrData,
	output word_t rdDataA,
	output word_t rdDataB
);

	word_t regs [4];

	always_ff @(posedge clk) begin
		if (wrEn)
			regs[wrAddr] <= wrData;
	end

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

// ==== source/tscCore.sv ====
`timescale 1ns/1ps
`include "tsc_consts.svh"

module tscCore import tscPkg::*; (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic loadEn,
	input logic [7:0] loadAddr,
	input instrWord_t loadInstr,
	output word_t outputPort,
	output logic wwdStrobe,
	output logic halted,
	output word_t numInst
);

	ctrlSigs_t ctrl;
	stageStrobes_t strobes;
	logic decodeValid;
	instrWord_t instr, fetchWord;
	word_t pc, memAddr, memWrData, memRdData;
	logic memWrEn;

	cpuSequencer cpuSequencer_i (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.ctrl(ctrl),
		.strobes(strobes),
		.decodeValid(decodeValid),
		.halted(halted)
	);

	controlUnit controlUnit_i (
		.instr(instr),
		.decodeValid(decodeValid),
		.ctrl(ctrl)
	);

	instCounter instCounter_i (
		.clk(clk),
		.rstN(rstN),
		.retire(strobes.commit),
		.numInst(numInst)
	);

	execDatapath execDatapath_i (
		.clk(clk),
		.rstN(rstN),
		.strobes(strobes),
		.ctrl(ctrl),
		.instrIn(fetchWord),
		.instr(instr),
		.pc(pc),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memRdData(memRdData),
		.memWrEn(memWrEn),
		.outputPort(outputPort),
		.wwdStrobe(wwdStrobe)
	);

	wordMemory #(.entryT(instrWord_t), .DEPTH(`IMEM_WORDS)) instMem_i (
		.clk(clk),
		.wrEn(loadEn),
		.wrAddr(loadAddr),
		.rdAddr(pc[$clog2(`IMEM_WORDS)-1:0]),
		.wrData(loadInstr),
		.rdData(fetchWord)
	);

	wordMemory #(.entryT(word_t), .DEPTH(`DMEM_WORDS)) dataMem_i (
		.clk(clk),
		.wrEn(memWrEn),
		.wrAddr(memAddr[$clog2(`DMEM_WORDS)-1:0]),
		.rdAddr(memAddr[$clog2(`DMEM_WORDS)-1:0]),
		.wrData(memWrData),
		.rdData(memRdData)
	);

endmodule

// ==== source/tscPkg.sv ====
`include "tsc_consts.svh"

package tscPkg;

	typedef logic [`WORD_SIZE-1:0] word_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [5:0] func;
	} instrWord_t;

	// same order as func codes 0..7.
	typedef enum logic [2:0] {ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR} aluOp_t;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK, WB_IMM} wbSel_t;
	typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_R2} destSel_t;
	typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_HIGH} immSel_t;
	typedef enum logic [1:0] {PC_SEQ, PC_TARGET, PC_REG} pcSrc_t;

	typedef struct packed {
		pcSrc_t pcSrc;
		logic regWrite;
		logic aluSrcB; // 1 selects the immediate.
		logic memWrite;
		logic memRead;
		logic branch;
		logic isWwd;
		logic isHalt;
		aluOp_t aluOp;
		wbSel_t wbSel;
		destSel_t destSel;
		immSel_t immSel;
	} ctrlSigs_t;

	typedef struct packed {
		logic irLoad;
		logic opLatch;
		logic exLatch;
		logic memAccess;
		logic commit;
	} stageStrobes_t;

endpackage

// ==== source/tsc_consts.svh ====
`ifndef TSC_CONSTS_SVH
`define TSC_CONSTS_SVH

`define WORD_SIZE 16

`define BNE_OP 4'd0
`define BEQ_OP 4'd1
`define BGZ_OP 4'd2
`define BLZ_OP 4'd3
`define ADI_OP 4'd4
`define ORI_OP 4'd5
`define LHI_OP 4'd6
`define LWD_OP 4'd7
`define SWD_OP 4'd8
`define JMP_OP 4'd9
`define JAL_OP 4'd10
`define ALU_OP 4'd15 // all R-type.

`define FUNC_ADD 6'd0
`define FUNC_SUB 6'd1
`define FUNC_AND 6'd2
`define FUNC_ORR 6'd3
`define FUNC_NOT 6'd4
`define FUNC_TCP 6'd5
`define FUNC_SHL 6'd6
`define FUNC_SHR 6'd7
`define FUNC_JPR 6'd25
`define FUNC_JRL 6'd26
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

`define IMEM_WORDS 256
`define DMEM_WORDS 256

`define LINK_REG 2'd2 // JAL and JRL write here.

`endif

// ==== source/wordMemory.sv ====
`timescale 1ns/1ps

module wordMemory #(
	parameter type entryT = logic [15:0],
	parameter int DEPTH = 256
) (
	input logic clk,
	input logic wrEn,
	input logic [$clog2(DEPTH)-1:0] wrAddr,
	input logic [$clog2(DEPTH)-1:0] rdAddr,
	input entryT wrData,
	output entryT rdData
);

	entryT mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	assign rdData = mem[rdAddr]; // asynchronous read.

endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period.
	end

endmodule

// ==== verification/tscCore_assert.sv ====
`timescale 1ns/1ps

module tscCore_assert import tscPkg::*; (
	input logic clk,
	input logic rstN,
	input logic wwdStrobe,
	input logic halted,
	input word_t numInst
);

	int assertFails = 0; // read by the testbench at the end.

	strobeSingle: assert property (@(posedge clk) disable iff (!rstN)
		wwdStrobe |=> !wwdStrobe)
		else begin
			$error("wwdStrobe high for two cycles in a row");
			assertFails++;
		end

	noStrobeHalted: assert property (@(posedge clk) disable iff (!rstN)
		halted |-> !wwdStrobe)
		else begin
			$error("wwdStrobe seen while halted");
			assertFails++;
		end

	countFrozen: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> (numInst == $past(numInst)))
		else begin
			$error("numInst changed while halted");
			assertFails++;
		end

	haltSticky: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted)
		else begin
			$error("halted dropped without reset");
			assertFails++;
		end

endmodule

bind tscCore tscCore_assert tscCore_assert_i (.*);

// ==== verification/tscTb.sv ====
`timescale 1ns/1ps
`include "tsc_consts.svh"

module tscTb import tscPkg::*; ();

	logic clk;
	logic rstN;
	logic start;
	logic loadEn;
	logic [7:0] loadAddr;
	instrWord_t loadInstr;
	word_t outputPort;
	logic wwdStrobe;
	logic halted;
	word_t numInst;

	instrWord_t prog [`IMEM_WORDS];
	int pos;
	int progEnd;
	word_t expQ [$];
	string testName;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	integer seed;

	clockGen clockGen_i (.clk(clk));

	tscCore dut_i (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadInstr(loadInstr),
		.outputPort(outputPort),
		.wwdStrobe(wwdStrobe),
		.halted(halted),
		.numInst(numInst)
	);

	function automatic word_t sext8(logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	// expected ALU result, straight from the instruction set rules.
	function automatic word_t refAlu(logic [5:0] func, word_t a, word_t b);
		case (func)
			`FUNC_ADD: return a + b;
			`FUNC_SUB: return a - b;
			`FUNC_AND: return a & b;
			`FUNC_ORR: return a | b;
			`FUNC_NOT: return ~a;
			`FUNC_TCP: return 16'd0 - a;
			`FUNC_SHL: return a << 1;
			`FUNC_SHR: return word_t'($signed(a) >>> 1);
			default: return 16'hxxxx;
		endcase
	endfunction

	function automatic bit refBranch(logic [3:0] op, word_t a, word_t b);
		case (op)
			`BNE_OP: return a != b;
			`BEQ_OP: return a == b;
			`BGZ_OP: return $signed(a) > 0;
			default: return $signed(a) < 0;
		endcase
	endfunction

	function automatic instrWord_t rType(logic [5:0] func, logic [1:0] rs, logic [1:0] rt,
		logic [1:0] rd);
		return {`ALU_OP, rs, rt, rd, func};
	endfunction

	function automatic instrWord_t iType(logic [3:0] op, logic [1:0] rs, logic [1:0] rt,
		logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instrWord_t jType(logic [3:0] op, logic [11:0] target);
		return {op, target};
	endfunction

	task automatic checkValue(string name, word_t expected, word_t actual);
		checkCount++;
		if (expected !== actual) begin
			$display("FAILED %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
			errorCount++;
		end
	endtask

	// compare process, one check per WWD strobe.
	always @(negedge clk) begin
		if (rstN && wwdStrobe) begin
			if (expQ.size() == 0) begin
				$display("ERROR %s: unexpected WWD output 0x%04h", testName, outputPort);
				errorCount++;
			end else begin
				checkValue(testName, expQ.pop_front(), outputPort);
			end
		end
	end

	task automatic newProgram();
		for (int i = 0; i < `IMEM_WORDS; i++)
			prog[i] = rType(`FUNC_HLT, 2'd0, 2'd0, 2'd0); // gaps stop the core.
		pos = 0;
		progEnd = 0;
		expQ.delete();
	endtask

	task automatic emit(instrWord_t w);
		prog[pos] = w;
		pos++;
		if (pos > progEnd)
			progEnd = pos;
	endtask

	task automatic loadConst(logic [1:0] r, word_t value);
		emit(iType(`LHI_OP, 2'd0, r, value[15:8]));
		emit(iType(`ORI_OP, r, r, value[7:0]));
	endtask

	task automatic wwd(logic [1:0] r);
		emit(rType(`FUNC_WWD, r, 2'd0, 2'd0));
	endtask

	task automatic halt();
		emit(rType(`FUNC_HLT, 2'd0, 2'd0, 2'd0));
	endtask

	// expInst below zero skips the retired count check.
	task automatic runProgram(string name, int expInst);
		int errBefore;
		int cycles;
		word_t lastOut;
		errBefore = errorCount;
		testName = name;
		lastOut = (expQ.size() > 0) ? expQ[$] : 16'h0000; // port holds the last WWD.
		@(posedge clk);
		#1 rstN = 1'b0;
		repeat (10) @(posedge clk);
		#1 rstN = 1'b1;
		checkValue({name, " outputPort after reset"}, 16'h0000, outputPort);
		for (int i = 0; i < progEnd; i++) begin
			@(posedge clk);
			#1;
			loadEn = 1'b1;
			loadAddr = i[7:0];
			loadInstr = prog[i];
		end
		@(posedge clk);
		#1;
		loadEn = 1'b0;
		start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
		cycles = 0;
		while (!halted && cycles < 2000) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("ERROR %s: core did not halt within 2000 cycles", name);
			errorCount++;
		end
		if (expQ.size() != 0) begin
			$display("ERROR %s: %0d expected WWD outputs never appeared", name, expQ.size());
			errorCount++;
		end
		checkValue({name, " outputPort held"}, lastOut, outputPort);
		if (expInst >= 0)
			checkValue({name, " numInst"}, word_t'(expInst), numInst);
		testCount++;
		$display("test %s finished with %0d errors", name, errorCount - errBefore);
	endtask

	task automatic arithTest();
		word_t a;
		word_t b;
		newProgram();
		a = sext8(8'hc5); // negative, so SHR must keep the sign.
		b = sext8(8'h35);
		emit(iType(`LHI_OP, 2'd0, 2'd0, 8'h00));
		emit(iType(`ADI_OP, 2'd0, 2'd0, 8'hc5));
		emit(iType(`LHI_OP, 2'd0, 2'd1, 8'h00));
		emit(iType(`ADI_OP, 2'd1, 2'd1, 8'h35));
		for (int f = 0; f < 8; f++) begin
			emit(rType(f[5:0], 2'd0, 2'd1, 2'd3));
			wwd(2'd3);
			expQ.push_back(refAlu(f[5:0], a, b));
		end
		halt();
		runProgram("arith", pos);
	endtask

	task automatic immTest();
		newProgram();
		emit(iType(`LHI_OP, 2'd0, 2'd0, 8'h00));
		emit(iType(`ADI_OP, 2'd0, 2'd1, 8'h80));
		wwd(2'd1);
		expQ.push_back(sext8(8'h80));
		emit(iType(`ORI_OP, 2'd0, 2'd1, 8'h80));
		wwd(2'd1);
		expQ.push_back(16'h0080); // zero-extended.
		emit(iType(`LHI_OP, 2'd0, 2'd1, 8'ha5));
		wwd(2'd1);
		expQ.push_back(16'ha500);
		emit(iType(`ADI_OP, 2'd1, 2'd1, 8'hfe));
		wwd(2'd1);
		expQ.push_back(16'ha500 + sext8(8'hfe));
		halt();
		runProgram("immediate", pos);
	endtask

	task automatic memTest();
		newProgram();
		loadConst(2'd0, 16'h0010); // base address.
		loadConst(2'd1, 16'h1234);
		emit(iType(`SWD_OP, 2'd0, 2'd1, 8'h03));
		loadConst(2'd1, 16'hbeef);
		emit(iType(`SWD_OP, 2'd0, 2'd1, 8'hfe));
		emit(iType(`LWD_OP, 2'd0, 2'd2, 8'h03));
		emit(iType(`LWD_OP, 2'd0, 2'd3, 8'hfe));
		wwd(2'd2);
		wwd(2'd3);
		expQ.push_back(16'h1234);
		expQ.push_back(16'hbeef);
		halt();
		runProgram("memory", pos);
	endtask

	task automatic branchTest();
		logic [3:0] brOp [8] = '{`BNE_OP, `BNE_OP, `BEQ_OP, `BEQ_OP,
			`BGZ_OP, `BGZ_OP, `BLZ_OP, `BLZ_OP};
		word_t brA [8] = '{16'h0005, 16'h0005, 16'h0009, 16'h0009,
			16'h0004, 16'h0000, 16'hfff0, 16'h0000};
		word_t brB [8] = '{16'h0007, 16'h0005, 16'h0009, 16'h0003,
			16'h0000, 16'h0000, 16'h0000, 16'h0000};
		word_t ntMark;
		word_t tMark;
		newProgram();
		for (int i = 0; i < 8; i++) begin
			ntMark = 16'h1100 + 16'(i);
			tMark = 16'h2200 + 16'(i);
			loadConst(2'd0, brA[i]);
			loadConst(2'd1, brB[i]);
			loadConst(2'd2, ntMark);
			loadConst(2'd3, tMark);
			emit(iType(brOp[i], 2'd0, 2'd1, 8'd2)); // taken lands on the second WWD.
			wwd(2'd2);
			emit(iType(`BEQ_OP, 2'd0, 2'd0, 8'd1));
			wwd(2'd3);
			expQ.push_back(refBranch(brOp[i], brA[i], brB[i]) ? tMark : ntMark);
		end
		halt();
		runProgram("branch", -1);
	endtask

	task automatic jumpTest();
		int jmpAt;
		int jalAt;
		int jrlAt;
		newProgram();
		loadConst(2'd0, 16'h00aa);
		loadConst(2'd1, 16'h00bb);
		loadConst(2'd3, 16'h0030);
		jmpAt = pos;
		emit(jType(`JMP_OP, 12'(jmpAt + 2)));
		wwd(2'd1); // skipped.
		wwd(2'd0);
		jalAt = pos;
		emit(jType(`JAL_OP, 12'h020));
		wwd(2'd2);
		jrlAt = pos;
		emit(rType(`FUNC_JRL, 2'd3, 2'd0, 2'd0));
		wwd(2'd2);
		halt();
		pos = 'h20;
		wwd(2'd1);
		emit(rType(`FUNC_JPR, 2'd2, 2'd0, 2'd0));
		pos = 'h30;
		wwd(2'd3);
		emit(rType(`FUNC_JPR, 2'd2, 2'd0, 2'd0));
		expQ.push_back(16'h00aa);
		expQ.push_back(16'h00bb);
		expQ.push_back(word_t'(jalAt + 1));
		expQ.push_back(16'h0030);
		expQ.push_back(word_t'(jrlAt + 1));
		runProgram("jump", -1);
	endtask

	task automatic randomTest();
		word_t a;
		word_t b;
		int fsel;
		newProgram();
		for (int k = 0; k < 20; k++) begin
			a = $random(seed);
			b = $random(seed);
			fsel = $unsigned($random(seed)) % 8;
			loadConst(2'd0, a);
			loadConst(2'd1, b);
			emit(rType(6'(fsel), 2'd0, 2'd1, 2'd3));
			wwd(2'd3);
			expQ.push_back(refAlu(6'(fsel), a, b));
		end
		halt();
		runProgram("random", pos); // straight line, HLT included.
	endtask

	initial begin
		rstN = 1'b0;
		start = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadInstr = '0;
		seed = 32'hb045_c1d5;
		testName = "none";
		arithTest();
		immTest();
		memTest();
		branchTest();
		jumpTest();
		randomTest();
		if (dut_i.tscCore_assert_i.assertFails != 0) begin
			$display("ERROR: %0d assertion failures during the run",
				dut_i.tscCore_assert_i.assertFails);
			errorCount += dut_i.tscCore_assert_i.assertFails;
		end
		$display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
			errorCount);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
